// File: verilog/z8Pkg.sv
package z8Pkg;

    typedef logic [7:0] byteT;

    // Low four bits are the opcode's high nibble
    typedef enum logic [4:0] {
        aluDec  = 5'h00,
        aluRlc  = 5'h01,
        aluInc  = 5'h02,
        aluLd   = 5'h03,  // Unused single-operand slot
        aluCom  = 5'h06,
        aluRl   = 5'h09,
        aluClr  = 5'h0B,
        aluRrc  = 5'h0C,
        aluSra  = 5'h0D,
        aluRr   = 5'h0E,
        aluSwap = 5'h0F,
        aluAdd  = 5'h10,
        aluAdc  = 5'h11,
        aluSub  = 5'h12,
        aluSbc  = 5'h13,
        aluOr   = 5'h14,
        aluAnd  = 5'h15,
        aluTcm  = 5'h16,
        aluTm   = 5'h17,
        aluCp   = 5'h1A,
        aluXor  = 5'h1B
    } aluOpT;

    // Bit positions in the flags register
    localparam int flagC = 7;
    localparam int flagZ = 6;
    localparam int flagS = 5;
    localparam int flagV = 4;
    localparam int flagD = 3;
    localparam int flagH = 2;

    localparam byteT regFlags   = 8'hFC;
    localparam byteT regPointer = 8'hFD;
    localparam logic [3:0] workingPrefix = 4'hE;

    localparam logic [3:0] lnAlu1  = 4'h0;
    localparam logic [3:0] lnSrp   = 4'h1;
    localparam logic [3:0] lnAluRr = 4'h2;
    localparam logic [3:0] lnAluRi = 4'h6;
    localparam logic [3:0] lnJr    = 4'hB;
    localparam logic [3:0] lnLdRi  = 4'hC;
    localparam logic [3:0] lnJp    = 4'hD;
    localparam logic [3:0] lnMisc  = 4'hF;

endpackage

// File: verilog/instrBus.sv
`timescale 1ns/1ps

interface instrBus;
    import z8Pkg::*;

    logic valid;
    logic ready;
    byteT opcode;
    byteT second;
    byteT third;
    logic redirect;    // Taken branch, only together with a transfer
    byteT redirectPc;

    modport fetch(output valid, opcode, second, third,
                  input ready, redirect, redirectPc);
    modport exec(input valid, opcode, second, third,
                 output ready, redirect, redirectPc);

endinterface

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::byteT  a,
    input  z8Pkg::byteT  b,
    input  z8Pkg::byteT  flagsIn,
    output z8Pkg::byteT  out,
    output z8Pkg::byteT  flagsOut
);
    import z8Pkg::*;

    logic carryIn;
    logic lowCarry;
    logic highCarry;

    assign carryIn = flagsIn[flagC] & op[0];  // adc and sbc only

    always_comb begin
        flagsOut = flagsIn;
        out = '0;
        lowCarry = 1'b0;
        highCarry = 1'b0;
        case (op)
            aluDec: begin
                out = a - 8'd1;
                flagsOut[flagV] = a[7] & ~out[7];
            end
            aluInc: begin
                out = a + 8'd1;
                flagsOut[flagV] = ~a[7] & out[7];
            end
            aluRlc: begin
                out = {a[6:0], flagsIn[flagC]};
                flagsOut[flagC] = a[7];
            end
            aluRl: begin
                out = {a[6:0], a[7]};
                flagsOut[flagC] = a[7];
            end
            aluRrc: begin
                out = {flagsIn[flagC], a[7:1]};
                flagsOut[flagC] = a[0];
            end
            aluSra: begin
                out = {a[7], a[7:1]};
                flagsOut[flagC] = a[0];
            end
            aluRr: begin
                out = {a[0], a[7:1]};
                flagsOut[flagC] = a[0];
            end
            aluCom: begin
                out = ~a;
                flagsOut[flagV] = 1'b0;
            end
            aluSwap: out = {a[3:0], a[7:4]};
            aluAdd, aluAdc: begin
                {lowCarry, out[3:0]} = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, carryIn};
                {highCarry, out[7:4]} = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'h0, lowCarry};
                flagsOut[flagD] = 1'b0;
            end
            aluSub, aluSbc, aluCp: begin
                {lowCarry, out[3:0]} = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'h0, carryIn};
                {highCarry, out[7:4]} = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'h0, lowCarry};
                flagsOut[flagD] = 1'b1;
            end
            aluOr: begin
                out = a | b;
                flagsOut[flagV] = 1'b0;
            end
            aluAnd, aluTcm, aluTm: begin
                out = (op[0] ? a : ~a) & b;  // tcm complements the destination
                flagsOut[flagV] = 1'b0;
            end
            aluXor: begin
                out = a ^ b;
                flagsOut[flagV] = 1'b0;
            end
            aluLd: out = a;
            default: out = '0;
        endcase

        // Carries and overflow shared by the arithmetic group
        if (op inside {aluAdd, aluAdc, aluSub, aluSbc, aluCp}) begin
            flagsOut[flagH] = lowCarry;
            flagsOut[flagC] = highCarry;
            flagsOut[flagV] = (a[7] == b[7]) & (a[7] != out[7]);
        end

        if (!(op inside {aluClr, aluLd})) begin
            flagsOut[flagZ] = out == 8'h00;
            flagsOut[flagS] = out[7];
        end
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int regCount = 128
) (
    input  logic        clk,
    input  logic        rstN,
    input  z8Pkg::byteT rdAddrA,
    input  z8Pkg::byteT rdAddrB,
    input  logic        wrValid,
    input  z8Pkg::byteT wrAddr,
    input  z8Pkg::byteT wrData,
    input  logic        flagsWrite,
    input  z8Pkg::byteT flagsIn,
    input  logic        carryWrite,
    input  logic        carryValue,
    input  logic        pointerWrite,
    input  logic [3:0]  pointerValue,
    output z8Pkg::byteT rdDataA,
    output z8Pkg::byteT rdDataB,
    output z8Pkg::byteT flags
);
    import z8Pkg::*;

    localparam int idxW = $clog2(regCount);

    byteT regs [regCount];
    logic [3:0] pointer;
    byteT mapA, mapB, mapW;

    // Working registers live in the pointer's bank
    function automatic byteT mapAddr(byteT addr, logic [3:0] rp);
        return (addr[7:4] == workingPrefix) ? {rp, addr[3:0]} : addr;
    endfunction

    function automatic byteT readReg(byteT addr);
        if (addr == regFlags) return flags;
        if (addr == regPointer) return {pointer, 4'h0};
        if (addr < regCount) return regs[addr[idxW-1:0]];
        return '0;
    endfunction

    assign mapA = mapAddr(rdAddrA, pointer);
    assign mapB = mapAddr(rdAddrB, pointer);
    assign mapW = mapAddr(wrAddr, pointer);

    always_comb begin
        rdDataA = readReg(mapA);
        rdDataB = readReg(mapB);
    end

    always_ff @(posedge clk) begin
        if (wrValid && mapW < regCount) begin
            regs[mapW[idxW-1:0]] <= wrData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
            pointer <= 4'h0;
        end else begin
            if (wrValid && mapW == regFlags) begin
                flags <= wrData;  // Beats the ALU flags
            end else if (flagsWrite) begin
                flags <= flagsIn;
            end else if (carryWrite) begin
                flags[flagC] <= carryValue;
            end
            if (wrValid && mapW == regPointer) begin
                pointer <= wrData[7:4];
            end else if (pointerWrite) begin
                pointer <= pointerValue;
            end
        end
    end

endmodule

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter z8Pkg::byteT resetPc = 8'h00
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        memReady,
    input  z8Pkg::byteT memRdata,
    output logic        memReq,
    output z8Pkg::byteT memAddr,
    instrBus.fetch      bus
);
    import z8Pkg::*;

    typedef enum logic [1:0] {
        sIdle,
        sReq,    // Request out, waiting for memReady
        sData,   // Byte on memRdata
        sValid   // Instruction offered to execute
    } stateT;

    stateT state;
    byteT pc;
    logic [1:0] byteIdx;
    logic [3:0] lowNibble;
    logic lastByte;
    byteT opcodeQ;
    byteT secondQ;
    byteT thirdQ;

    function automatic logic [1:0] instrLength(logic [3:0] nibble);
        if (nibble == 4'hE || nibble == lnMisc) begin
            return 2'd1;
        end
        if (nibble[3:2] == 2'b01 || nibble == lnJp) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    // Opcode comes straight from memory on the first byte
    assign lowNibble = (byteIdx == 2'd0) ? memRdata[3:0] : opcodeQ[3:0];
    assign lastByte = (byteIdx + 2'd1) == instrLength(lowNibble);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            pc <= resetPc;
            byteIdx <= 2'd0;
        end else begin
            case (state)
                sIdle: state <= sReq;
                sReq: begin
                    if (memReady) begin
                        pc <= pc + 8'd1;
                        state <= sData;
                    end
                end
                sData: begin
                    if (lastByte) begin
                        byteIdx <= 2'd0;
                        state <= sValid;
                    end else begin
                        byteIdx <= byteIdx + 2'd1;
                        state <= sReq;
                    end
                end
                default: begin
                    if (bus.ready) begin
                        state <= sReq;  // Next fetch overlaps execute
                        if (bus.redirect) begin
                            pc <= bus.redirectPc;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sData) begin
            case (byteIdx)
                2'd0: opcodeQ <= memRdata;
                2'd1: secondQ <= memRdata;
                default: thirdQ <= memRdata;
            endcase
        end
    end

    assign memReq = state == sReq;
    assign memAddr = pc;  // Past the instruction once it is complete

    assign bus.valid = state == sValid;
    assign bus.opcode = opcodeQ;
    assign bus.second = secondQ;
    assign bus.third = thirdQ;

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic         clk,
    input  logic         rstN,
    input  z8Pkg::byteT  flags,
    input  z8Pkg::byteT  rdDataA,
    input  z8Pkg::byteT  rdDataB,
    input  z8Pkg::byteT  aluOut,
    input  z8Pkg::byteT  aluFlags,
    input  z8Pkg::byteT  curPc,
    output z8Pkg::byteT  rdAddrA,
    output z8Pkg::byteT  rdAddrB,
    output z8Pkg::aluOpT aluOp,
    output z8Pkg::byteT  aluA,
    output z8Pkg::byteT  aluB,
    output logic         wrValid,
    output z8Pkg::byteT  wrAddr,
    output z8Pkg::byteT  wrData,
    output logic         flagsWrite,
    output z8Pkg::byteT  flagsValue,
    output logic         carryWrite,
    output logic         carryValue,
    output logic         pointerWrite,
    output logic [3:0]   pointerValue,
    instrBus.exec        bus
);
    import z8Pkg::*;

    logic busy;
    logic fire;
    logic [3:0] hi;
    logic [3:0] lo;
    logic isAlu1, isAlu2, isLdImm, isJump, taken;
    aluOpT opNext, opQ;
    byteT aNext, bNext, dstNext;
    byteT aQ, bQ, dstQ;

    function automatic logic condition(logic [3:0] cc, byteT f);
        logic c;
        case (cc[2:0])
            3'd0: c = 1'b0;
            3'd1: c = f[flagS] ^ f[flagV];
            3'd2: c = (f[flagS] ^ f[flagV]) | f[flagZ];
            3'd3: c = f[flagC] | f[flagZ];
            3'd4: c = f[flagV];
            3'd5: c = f[flagS];
            3'd6: c = f[flagZ];
            default: c = f[flagC];
        endcase
        return c ^ cc[3];
    endfunction

    assign hi = bus.opcode[7:4];
    assign lo = bus.opcode[3:0];
    assign fire = bus.valid & bus.ready;
    assign bus.ready = ~busy;

    // Everything else runs as nop
    assign isAlu1 = lo == lnAlu1 &&
                    hi inside {4'h0, 4'h1, 4'h2, 4'h6, 4'h9, [4'hB:4'hF]};
    assign isAlu2 = (lo == lnAluRr || lo == lnAluRi) && hi inside {[4'h0:4'h7], 4'hA, 4'hB};
    assign isLdImm = lo == lnLdRi || (lo == lnAluRi && hi == 4'hE);

    always_comb begin
        rdAddrA = bus.second;
        rdAddrB = bus.third;
        dstNext = bus.second;
        aNext = rdDataA;
        bNext = bus.third;
        opNext = aluLd;
        if (lo == lnAluRr) begin  // r, r form
            rdAddrA = {workingPrefix, bus.second[7:4]};
            rdAddrB = {workingPrefix, bus.second[3:0]};
            dstNext = rdAddrA;
            bNext = rdDataB;
        end
        if (isAlu1) begin
            opNext = aluOpT'({1'b0, hi});
        end else if (isAlu2) begin
            opNext = aluOpT'({1'b1, hi});
        end else if (lo == lnLdRi) begin
            dstNext = {workingPrefix, hi};
            aNext = bus.second;
        end else begin
            aNext = bus.third;  // ld R, #imm
        end
    end

    assign taken = condition(hi, flags);
    assign isJump = lo == lnJr || lo == lnJp;
    assign bus.redirect = fire & isJump & taken;
    assign bus.redirectPc = (lo == lnJp) ? bus.third : curPc + bus.second;

    // scf, rcf, ccf
    assign carryWrite = fire && lo == lnMisc && hi inside {4'hC, 4'hD, 4'hE};
    assign carryValue = (hi == 4'hE) ? ~flags[flagC] : hi[0];
    assign pointerWrite = fire && lo == lnSrp && hi == 4'h3;
    assign pointerValue = bus.second[7:4];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else begin
            busy <= fire & (isAlu1 | isAlu2 | isLdImm);  // Single execute cycle
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            opQ <= opNext;
            aQ <= aNext;
            bQ <= bNext;
            dstQ <= dstNext;
        end
    end

    assign aluOp = opQ;
    assign aluA = aQ;
    assign aluB = bQ;
    assign wrValid = busy && !(opQ inside {aluTcm, aluTm, aluCp});
    assign wrAddr = dstQ;
    assign wrData = aluOut;
    assign flagsWrite = busy && opQ != aluLd;
    assign flagsValue = aluFlags;

endmodule

// File: verilog/z8Core.sv
`timescale 1ns/1ps

module z8Core #(
    parameter z8Pkg::byteT resetPc = 8'h00,
    parameter int regCount = 128
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        memReady,
    input  z8Pkg::byteT memRdata,
    output logic        memReq,
    output z8Pkg::byteT memAddr,
    output logic        regWrValid,
    output z8Pkg::byteT regWrAddr,
    output z8Pkg::byteT regWrData,
    output z8Pkg::byteT flags
);
    import z8Pkg::*;

    byteT rdAddrA, rdAddrB, rdDataA, rdDataB;
    aluOpT aluOp;
    byteT aluA, aluB, aluOut, aluFlags, flagsValue;
    logic flagsWrite, carryWrite, carryValue, pointerWrite;
    logic [3:0] pointerValue;

    instrBus bus ();

    fetchUnit #(.resetPc(resetPc)) fetch0 (
        .clk(clk), .rstN(rstN),
        .memReady(memReady), .memRdata(memRdata),
        .memReq(memReq), .memAddr(memAddr),
        .bus(bus.fetch)
    );

    // memAddr is the fall-through PC while an instruction is offered
    execUnit exec0 (
        .clk(clk), .rstN(rstN),
        .flags(flags), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .aluOut(aluOut), .aluFlags(aluFlags), .curPc(memAddr),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .wrValid(regWrValid), .wrAddr(regWrAddr), .wrData(regWrData),
        .flagsWrite(flagsWrite), .flagsValue(flagsValue),
        .carryWrite(carryWrite), .carryValue(carryValue),
        .pointerWrite(pointerWrite), .pointerValue(pointerValue),
        .bus(bus.exec)
    );

    registerFile #(.regCount(regCount)) regFile0 (
        .clk(clk), .rstN(rstN),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wrValid(regWrValid), .wrAddr(regWrAddr), .wrData(regWrData),
        .flagsWrite(flagsWrite), .flagsIn(flagsValue),
        .carryWrite(carryWrite), .carryValue(carryValue),
        .pointerWrite(pointerWrite), .pointerValue(pointerValue),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .flags(flags)
    );

    alu alu0 (
        .op(aluOp), .a(aluA), .b(aluB), .flagsIn(flags),
        .out(aluOut), .flagsOut(aluFlags)
    );

endmodule

// File: test/z8CoreTb.sv
`timescale 1ns/1ps

module z8CoreTb;
    import z8Pkg::*;

    localparam int cycleLimit = 4000;  // Several times the expected length of all runs

    logic clk, rstN, memReady, memReq, regWrValid;
    byteT memRdata, memAddr, regWrAddr, regWrData, flags;

    byteT prog [256];
    byteT loadPos, endAddr, lastFlags;
    bit stall;
    int endHits;
    int cycles;
    logic [16:0] log [$];   // {isFlags, addr, data}
    logic [16:0] exp [$];
    byteT mRegs [128];
    byteT mFlags;
    logic [3:0] mRp;

    z8Core #(.resetPc(8'h00), .regCount(128)) dut0 (
        .clk(clk), .rstN(rstN), .memReady(memReady), .memRdata(memRdata),
        .memReq(memReq), .memAddr(memAddr), .regWrValid(regWrValid),
        .regWrAddr(regWrAddr), .regWrData(regWrData), .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory with random back-pressure
    initial begin
        logic accepted;
        byteT addr;
        void'($urandom(32'hc49fc0b0));
        forever begin
            @(posedge clk);
            accepted = memReq && memReady;
            addr = memAddr;
            if (rstN && accepted && addr == endAddr) endHits++;
            #1;
            if (accepted) memRdata = prog[addr];
            memReady = stall ? ($urandom % 8 == 0) : ($urandom % 4 != 0);
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            if (regWrValid) log.push_back({1'b0, regWrAddr, regWrData});
            if (flags != lastFlags) begin
                log.push_back({1'b1, regFlags, flags});
                lastFlags = flags;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the core did not reach the end of the program");
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "check failed");
    endtask

    task automatic newProgram;
        for (int i = 0; i < 256; i++) prog[i] = byteT'(i) ^ 8'hA5;
        loadPos = 8'h00;
    endtask

    task automatic instr(input int len, input byteT b0, input byteT b1 = 0,
                         input byteT b2 = 0);
        prog[loadPos] = b0;
        if (len > 1) prog[loadPos + 8'd1] = b1;
        if (len > 2) prog[loadPos + 8'd2] = b2;
        loadPos = loadPos + byteT'(len);
    endtask

    task automatic finishProgram;
        endAddr = loadPos;
        instr(3, 8'h8D, 8'h00, endAddr);  // Self jump marks the end
    endtask

    function automatic logic condTrue(logic [3:0] cc, byteT f);
        logic c;
        case (cc[2:0])
            3'd0: c = 1'b0;
            3'd1: c = f[flagS] != f[flagV];
            3'd2: c = (f[flagS] != f[flagV]) || f[flagZ];
            3'd3: c = f[flagC] || f[flagZ];
            3'd4: c = f[flagV];
            3'd5: c = f[flagS];
            3'd6: c = f[flagZ];
            default: c = f[flagC];
        endcase
        return cc[3] ? !c : c;
    endfunction

    task automatic aluModel(input logic [4:0] op, input byteT a, input byteT b,
                            input byteT f, output byteT r, output byteT nf);
        logic [8:0] wide;
        logic cin;
        nf = f;
        r = 8'h00;
        cin = op[0] & f[flagC];
        case (op)
            5'h00: begin
                r = a - 8'd1;
                nf[flagV] = a == 8'h80;
            end
            5'h02: begin
                r = a + 8'd1;
                nf[flagV] = a == 8'h7F;
            end
            5'h01: begin
                r = {a[6:0], f[flagC]};
                nf[flagC] = a[7];
            end
            5'h09: begin
                r = {a[6:0], a[7]};
                nf[flagC] = a[7];
            end
            5'h0C: begin
                r = {f[flagC], a[7:1]};
                nf[flagC] = a[0];
            end
            5'h0D: begin
                r = {a[7], a[7:1]};
                nf[flagC] = a[0];
            end
            5'h0E: begin
                r = {a[0], a[7:1]};
                nf[flagC] = a[0];
            end
            5'h06: begin
                r = ~a;
                nf[flagV] = 1'b0;
            end
            5'h0B: r = 8'h00;
            5'h0F: r = {a[3:0], a[7:4]};
            5'h10, 5'h11: begin
                wide = {1'b0, a} + {1'b0, b} + {8'h00, cin};
                r = wide[7:0];
                nf[flagC] = wide[8];
                nf[flagH] = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cin}) > 5'd15;
                nf[flagD] = 1'b0;
                nf[flagV] = (a[7] == b[7]) && (r[7] != a[7]);
            end
            5'h12, 5'h13, 5'h1A: begin
                wide = {1'b0, a} - {1'b0, b} - {8'h00, cin};
                r = wide[7:0];
                nf[flagC] = wide[8];  // Borrow
                nf[flagH] = {1'b0, a[3:0]} < ({1'b0, b[3:0]} + {4'h0, cin});
                nf[flagD] = 1'b1;
                nf[flagV] = (a[7] == b[7]) && (r[7] != a[7]);
            end
            5'h14: begin
                r = a | b;
                nf[flagV] = 1'b0;
            end
            5'h15, 5'h17: begin
                r = a & b;
                nf[flagV] = 1'b0;
            end
            5'h16: begin
                r = ~a & b;
                nf[flagV] = 1'b0;
            end
            default: begin
                r = a ^ b;
                nf[flagV] = 1'b0;
            end
        endcase
        if (op != 5'h0B) begin
            nf[flagZ] = r == 8'h00;
            nf[flagS] = r[7];
        end
    endtask

    function automatic byteT mapModel(byteT addr);
        return (addr[7:4] == 4'hE) ? {mRp, addr[3:0]} : addr;
    endfunction

    function automatic byteT readModel(byteT addr);
        byteT m;
        m = mapModel(addr);
        if (m == 8'hFC) return mFlags;
        if (m == 8'hFD) return {mRp, 4'h0};
        if (m < 8'd128) return mRegs[m[6:0]];
        return 8'h00;
    endfunction

    task automatic setModelFlags(input byteT v);
        if (v != mFlags) exp.push_back({1'b1, regFlags, v});
        mFlags = v;
    endtask

    task automatic writeModel(input byteT addr, input byteT v);
        byteT m;
        exp.push_back({1'b0, addr, v});
        m = mapModel(addr);
        if (m == 8'hFC) setModelFlags(v);
        else if (m == 8'hFD) mRp = v[7:4];
        else if (m < 8'd128) mRegs[m[6:0]] = v;
    endtask

    // Instruction-level reference run over prog
    task automatic modelRun;
        byteT pc, op, s, t, nextPc, dst, a, b, r, nf;
        logic [3:0] hi, lo;
        pc = 8'h00;
        mFlags = 8'h00;
        mRp = 4'h0;
        exp.delete();
        for (int i = 0; i < 128; i++) mRegs[i] = 8'h00;
        for (int steps = 0; steps < 400; steps++) begin
            op = prog[pc];
            s = prog[pc + 8'd1];
            t = prog[pc + 8'd2];
            hi = op[7:4];
            lo = op[3:0];
            if (lo >= 4'hE) nextPc = pc + 8'd1;
            else if ((lo >= 4'h4 && lo <= 4'h7) || lo == 4'hD) nextPc = pc + 8'd3;
            else nextPc = pc + 8'd2;
            if (op == 8'h8D && t == pc) break;
            if (lo == 4'h0 && hi inside {4'h0, 4'h1, 4'h2, 4'h6, 4'h9, [4'hB:4'hF]}) begin
                aluModel({1'b0, hi}, readModel(s), 8'h00, mFlags, r, nf);
                writeModel(s, r);
                setModelFlags(nf);
            end else if ((lo == 4'h2 || lo == 4'h6) && (hi <= 4'h7 || hi inside {4'hA, 4'hB})) begin
                dst = (lo == 4'h2) ? {4'hE, s[7:4]} : s;
                b = (lo == 4'h2) ? readModel({4'hE, s[3:0]}) : t;
                a = readModel(dst);
                aluModel({1'b1, hi}, a, b, mFlags, r, nf);
                if (!(hi inside {4'h6, 4'h7, 4'hA})) writeModel(dst, r);  // tcm, tm, cp
                setModelFlags(nf);
            end else if (lo == 4'hC) begin
                writeModel({4'hE, hi}, s);
            end else if (op == 8'hE6) begin
                writeModel(s, t);
            end else if (op == 8'h31) begin
                mRp = s[7:4];
            end else if (lo == 4'hB) begin
                if (condTrue(hi, mFlags)) nextPc = nextPc + s;
            end else if (lo == 4'hD) begin
                if (condTrue(hi, mFlags)) nextPc = t;
            end else if (op inside {8'hCF, 8'hDF, 8'hEF}) begin
                nf = mFlags;
                nf[flagC] = (op == 8'hEF) ? !mFlags[flagC] : op[4];
                setModelFlags(nf);
            end
            pc = nextPc;
        end
    endtask

    task automatic runDut(input bit slow);
        @(posedge clk);
        #1 rstN = 1'b0;
        stall = slow;
        log.delete();
        endHits = 0;
        lastFlags = 8'h00;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        while (endHits < 2) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic compareLogs(input string name);
        assert (log.size() == exp.size()) else
            reportMismatch($sformatf("%s: %0d events, expected %0d", name, log.size(),
                                     exp.size()));
        for (int i = 0; i < exp.size(); i++) begin
            assert (log[i] == exp[i]) else
                reportMismatch($sformatf("%s: event %0d is %h, expected %h", name, i,
                                         log[i], exp[i]));
        end
    endtask

    task automatic checkProgram(input string name);
        finishProgram();
        modelRun();
        runDut(1'b0);
        compareLogs(name);
    endtask

    task automatic loadsAndMapping;
        newProgram();
        instr(3, 8'hE6, 8'h10, 8'h11);
        instr(2, 8'h1C, 8'h22);
        instr(2, 8'h31, 8'h20);  // Bank 2
        instr(2, 8'h3C, 8'h33);
        instr(3, 8'hE6, 8'hFD, 8'h40);
        instr(2, 8'h4C, 8'h44);
        instr(3, 8'hE6, 8'hFC, 8'hA5);
        checkProgram("loads");
        assert (flags == 8'hA5) else
            reportMismatch($sformatf("flags output %h after load, expected a5", flags));
    endtask

    task automatic twoOperandArith;
        newProgram();
        instr(2, 8'h31, 8'h30);
        instr(2, 8'h0C, 8'h7F);
        instr(2, 8'h1C, 8'h01);
        instr(2, 8'h02, 8'h01);
        instr(2, 8'h12, 8'h01);
        instr(2, 8'h22, 8'h01);
        instr(3, 8'h06, 8'h30, 8'h80);
        instr(3, 8'h26, 8'h31, 8'h05);
        instr(2, 8'h32, 8'h10);
        instr(2, 8'hA2, 8'h01);
        instr(3, 8'h76, 8'h30, 8'h0F);
        instr(3, 8'hA6, 8'h31, 8'hFC);
        instr(3, 8'h16, 8'h31, 8'hFF);
        instr(3, 8'h36, 8'h30, 8'h01);
        checkProgram("arith");
    endtask

    task automatic singleOperandOps;
        byteT firstOps [5];
        byteT secondOps [6];
        firstOps = '{8'h00, 8'h10, 8'h20, 8'h60, 8'h90};
        secondOps = '{8'h20, 8'hC0, 8'hD0, 8'hE0, 8'hF0, 8'hB0};
        newProgram();
        instr(2, 8'h0C, 8'h80);
        foreach (firstOps[i]) begin
            instr(2, firstOps[i], 8'hE0);
        end
        instr(2, 8'h0C, 8'h7F);
        foreach (secondOps[i]) begin
            instr(2, secondOps[i], 8'hE0);
        end
        checkProgram("single");
    endtask

    task automatic conditionalJumps;
        byteT cc;
        newProgram();
        for (int i = 0; i < 16; i++) begin
            cc = byteT'(i);
            instr(2, 8'h0C, cc * 8'd37);
            instr(2, 8'h1C, cc * 8'd91);
            instr(2, 8'hA2, 8'h01);          // cp sets the flags
            instr(2, {cc[3:0], 4'hB}, 8'h02);
            instr(2, 8'h5C, cc);             // Skipped when taken
            instr(3, {cc[3:0], 4'hD}, 8'h00, loadPos + 8'd5);
            instr(2, 8'h6C, cc);
        end
        checkProgram("jumps");
    endtask

    task automatic carryOps;
        newProgram();
        instr(2, 8'h0C, 8'h10);
        instr(2, 8'h1C, 8'h20);
        instr(1, 8'hDF);
        instr(2, 8'h12, 8'h01);
        instr(1, 8'hCF);
        instr(2, 8'h12, 8'h01);
        instr(1, 8'hEF);
        instr(2, 8'h12, 8'h01);
        instr(1, 8'hEF);
        instr(2, 8'h12, 8'h01);
        checkProgram("carry");
        runDut(1'b1);
        compareLogs("carry stalled");
    endtask

    initial begin
        rstN = 1'b0;
        memReady = 1'b0;
        memRdata = 8'h00;
        stall = 1'b0;
        cycles = 0;
        endHits = 0;
        endAddr = 8'hFF;
        lastFlags = 8'h00;
        loadsAndMapping();
        twoOperandArith();
        singleOperandOps();
        conditionalJumps();
        carryOps();
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
verilog/z8Pkg.sv
verilog/instrBus.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/fetchUnit.sv
verilog/execUnit.sv
verilog/z8Core.sv
test/z8CoreTb.sv

// File: Makefile
SIM := obj_dir/Vz8CoreTb
SRCS := $(wildcard verilog/*.sv test/*.sv)

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module z8CoreTb -f verilog.f -o Vz8CoreTb

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean
